//--- compile.f
+incdir+hdl
hdl/sdram_tester_pkg.sv
hdl/prompt_text.sv
hdl/tx_pacer.sv
hdl/hex_entry.sv
hdl/tester_ctrl.sv
hdl/sdram_tester_top.sv
testbench/sdram_tester_props.sv
testbench/tb_sdram_tester.sv

//--- hdl/hex_entry.sv
/* collects i_digits hex characters, echoing each accepted one
   non hex bytes are dropped silently, value is right aligned */
`timescale 1ns/100ps
`include "sdram_tester_cfg.svh"

module hex_entry (
  input  logic                              i_clk,
  input  logic                              i_rstn,
  input  logic                              i_start,
  input  logic [$clog2(`DATA_DIGITS+1)-1:0] i_digits,
  input  logic                              i_rx_done,
  input  logic [7:0]                        i_rx_data,
  output logic [`DATA_W-1:0]                o_value,
  output sdram_tester_pkg::tx_byte_t        o_tx,
  output logic                              o_done
);
  localparam int DIG_W = $clog2(`DATA_DIGITS + 1);

  logic             active;
  logic [DIG_W-1:0] digits_q;
  logic [DIG_W-1:0] count;
  logic             is_hex;
  logic [3:0]       nibble;
  logic             accept;

  // ascii to nibble, letters in either case
  always_comb
  begin
    is_hex = 1'b1;
    nibble = i_rx_data[3:0];
    if (i_rx_data >= 8'h30 && i_rx_data <= 8'h39)
      nibble = i_rx_data[3:0];
    else if ((i_rx_data >= 8'h41 && i_rx_data <= 8'h46) ||
             (i_rx_data >= 8'h61 && i_rx_data <= 8'h66))
      nibble = i_rx_data[3:0] + 4'd9;
    else
      is_hex = 1'b0;
  end

  assign accept = active && i_rx_done && is_hex;

  always_ff @(posedge i_clk)
  begin
    if (!i_rstn)
    begin
      active <= 1'b0;
      count <= '0;
      o_tx <= '0;
      o_done <= 1'b0;
    end
    else
    begin
      o_tx <= '0;
      o_done <= 1'b0;
      if (i_start)
      begin
        active <= 1'b1;
        count <= '0;
      end
      else if (accept)
      begin
        o_tx <= {1'b1, i_rx_data};  // echo
        count <= count + 1'b1;
        if (count + 1'b1 == digits_q)
        begin
          active <= 1'b0;
          o_done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge i_clk)
  begin
    if (i_start)
    begin
      digits_q <= i_digits;
      o_value <= '0;
    end
    else if (accept)
      o_value <= {o_value[`DATA_W-5:0], nibble};  // new digit enters low
  end

endmodule

//--- hdl/prompt_text.sv
/* combinational text rom for all messages
   bytes past the message length read as zero */
`timescale 1ns/100ps
`include "sdram_tester_cfg.svh"

module prompt_text (
  input  sdram_tester_pkg::msg_id_t       i_msg_id,
  input  logic [$clog2(`MSG_MAX_LEN)-1:0] i_idx,
  input  sdram_tester_pkg::data_word_u    i_rdata,
  output logic [7:0]                      o_byte,
  output logic [$clog2(`MSG_MAX_LEN)-1:0] o_len
);
  import sdram_tester_pkg::*;

  localparam int IDX_W = $clog2(`MSG_MAX_LEN);
  localparam int TXT_W = 8 * `MSG_MAX_LEN;
  localparam int NIB_W = $clog2(`DATA_DIGITS);

  localparam logic [TXT_W-1:0] TXT_MENU  = "SDRAM TESTER\015\012Options: 1-Write, 2-Read\015\012";
  localparam logic [TXT_W-1:0] TXT_WRITE = "WRITE\015\012Enter 32-bit data:\015\012";
  localparam logic [TXT_W-1:0] TXT_WADDR = "\015\012Enter 24-bit address:\015\012";
  localparam logic [TXT_W-1:0] TXT_WOK   = "\015\012Data write ok!\015\012";
  localparam logic [TXT_W-1:0] TXT_READ  = "READ\015\012Enter 24-bit address:\015\012";
  localparam logic [TXT_W-1:0] TXT_RPRE  = "\015\012Read data: ";
  localparam logic [TXT_W-1:0] TXT_CRLF  = "\015\012";

  localparam logic [IDX_W-1:0] LEN_MENU  = IDX_W'(40);
  localparam logic [IDX_W-1:0] LEN_WRITE = IDX_W'(27);
  localparam logic [IDX_W-1:0] LEN_WADDR = IDX_W'(25);
  localparam logic [IDX_W-1:0] LEN_WOK   = IDX_W'(18);
  localparam logic [IDX_W-1:0] LEN_READ  = IDX_W'(29);
  localparam logic [IDX_W-1:0] LEN_RPRE  = IDX_W'(13);
  localparam logic [IDX_W-1:0] LEN_CRLF  = IDX_W'(2);
  localparam logic [IDX_W-1:0] LEN_HEX   = IDX_W'(`DATA_DIGITS);
  localparam logic [IDX_W-1:0] LEN_RDATA = LEN_RPRE + LEN_HEX + LEN_CRLF;

  logic [IDX_W-1:0] tail_idx;  // index behind the read prefix
  logic [NIB_W-1:0] nib_sel;

  // strings are right aligned, first char sits highest
  function automatic logic [7:0] text_byte(input logic [TXT_W-1:0] txt,
                                           input logic [IDX_W-1:0] len,
                                           input logic [IDX_W-1:0] idx);
    logic [7:0] b;
    b = 8'h00;
    if (idx < len)
      b = txt[8*(len-1-idx) +: 8];
    return b;
  endfunction

  function automatic logic [7:0] hex_char(input logic [3:0] nib);
    if (nib < 4'd10)
      return 8'h30 + {4'h0, nib};
    else
      return 8'h37 + {4'h0, nib};  // upper case A..F
  endfunction

  assign tail_idx = i_idx - LEN_RPRE;
  assign nib_sel = tail_idx[NIB_W-1:0];

  always_comb
  begin
    o_len = LEN_RDATA;
    case (i_msg_id)
      MSG_MENU:
      begin
        o_len = LEN_MENU;
        o_byte = text_byte(TXT_MENU, LEN_MENU, i_idx);
      end
      MSG_WRITE:
      begin
        o_len = LEN_WRITE;
        o_byte = text_byte(TXT_WRITE, LEN_WRITE, i_idx);
      end
      MSG_WADDR:
      begin
        o_len = LEN_WADDR;
        o_byte = text_byte(TXT_WADDR, LEN_WADDR, i_idx);
      end
      MSG_WOK:
      begin
        o_len = LEN_WOK;
        o_byte = text_byte(TXT_WOK, LEN_WOK, i_idx);
      end
      MSG_READ:
      begin
        o_len = LEN_READ;
        o_byte = text_byte(TXT_READ, LEN_READ, i_idx);
      end
      default:
      begin
        if (i_idx < LEN_RPRE)
          o_byte = text_byte(TXT_RPRE, LEN_RPRE, i_idx);
        else if (tail_idx < LEN_HEX)
          o_byte = hex_char(i_rdata.nibbles[nib_sel]);
        else
          o_byte = text_byte(TXT_CRLF, LEN_CRLF, tail_idx - LEN_HEX);
      end
    endcase
  end

endmodule

//--- hdl/sdram_tester_cfg.svh
/* build constants of the tester
   ADDR_W has to stay 4 * ADDR_DIGITS and DATA_W 4 * DATA_DIGITS
   MSG_MAX_LEN bounds every prompt and sizes the byte index */
`ifndef SDRAM_TESTER_CFG_SVH
`define SDRAM_TESTER_CFG_SVH

// hex digits typed per field
`define DATA_DIGITS 8
`define ADDR_DIGITS 6

// memory bus widths
`define ADDR_W 24
`define DATA_W 32

// idle cycles of tx_busy before the next paced byte
`define PACE_IDLE_CYCLES 8

// longest message in bytes
`define MSG_MAX_LEN 48

`endif

//--- hdl/sdram_tester_pkg.sv
/* shared types of the tester
   mem_req_t is 61 bits wide with the default widths */
`include "sdram_tester_cfg.svh"

package sdram_tester_pkg;

  // memory request, fields held until ready
  typedef struct packed {
    logic                 valid;
    logic [3:0]           wstrb;  // all ones for write, zero for read
    logic [`ADDR_W-1:0]   addr;
    logic [`DATA_W-1:0]   wdata;
  } mem_req_t;

  // one byte towards the uart transmitter
  typedef struct packed {
    logic       en;    // one cycle per byte
    logic [7:0] data;
  } tx_byte_t;

  // selects the text printed by the pacer
  typedef enum logic [2:0] {
    MSG_MENU,
    MSG_WRITE,
    MSG_WADDR,
    MSG_WOK,
    MSG_READ,
    MSG_RDATA
  } msg_id_t;

  /* read word as seen by the bus and by the hex printer
     nibbles[0] is the most significant digit */
  typedef union packed {
    logic [`DATA_W-1:0]                 word;
    logic [0:`DATA_DIGITS-1][3:0]       nibbles;
  } data_word_u;

endpackage

//--- hdl/sdram_tester_top.sv
/* uart driven sdram tester, byte wide uart and single word memory port
   i_rx_done and i_mem_ready are one cycle strobes */
`timescale 1ns/100ps
`include "sdram_tester_cfg.svh"

module sdram_tester_top (
  input  logic                       i_clk,
  input  logic                       i_rstn,
  input  logic                       i_rx_done,
  input  logic [7:0]                 i_rx_data,
  input  logic                       i_tx_busy,
  output sdram_tester_pkg::tx_byte_t o_tx,
  input  logic                       i_mem_ready,
  input  logic [`DATA_W-1:0]         i_mem_rdata,
  output sdram_tester_pkg::mem_req_t o_mem_req
);
  import sdram_tester_pkg::*;

  localparam int IDX_W = $clog2(`MSG_MAX_LEN);
  localparam int DIG_W = $clog2(`DATA_DIGITS + 1);

  logic               msg_start;
  msg_id_t            msg_id;
  logic               msg_done;
  tx_byte_t           pacer_tx;
  logic               entry_start;
  logic [DIG_W-1:0]   entry_digits;
  logic               entry_done;
  logic [`DATA_W-1:0] entry_value;
  tx_byte_t           entry_tx;
  data_word_u         rdata;
  msg_id_t            text_id;
  logic [IDX_W-1:0]   text_idx;
  logic [7:0]         text_byte;
  logic [IDX_W-1:0]   text_len;

  tester_ctrl u_ctrl (
    .i_clk(i_clk), .i_rstn(i_rstn), .i_rx_done(i_rx_done), .i_rx_data(i_rx_data),
    .i_mem_ready(i_mem_ready), .i_mem_rdata(i_mem_rdata), .o_mem_req(o_mem_req),
    .o_tx(o_tx), .o_msg_start(msg_start), .o_msg_id(msg_id), .i_msg_done(msg_done),
    .i_pacer_tx(pacer_tx), .o_entry_start(entry_start), .o_entry_digits(entry_digits),
    .i_entry_done(entry_done), .i_entry_value(entry_value), .i_entry_tx(entry_tx),
    .o_rdata(rdata)
  );

  tx_pacer u_pacer (
    .i_clk(i_clk), .i_rstn(i_rstn), .i_start(msg_start), .i_msg_id(msg_id),
    .i_tx_busy(i_tx_busy), .o_text_id(text_id), .o_text_idx(text_idx),
    .i_text_byte(text_byte), .i_text_len(text_len), .o_tx(pacer_tx), .o_done(msg_done)
  );

  hex_entry u_entry (
    .i_clk(i_clk), .i_rstn(i_rstn), .i_start(entry_start), .i_digits(entry_digits),
    .i_rx_done(i_rx_done), .i_rx_data(i_rx_data), .o_value(entry_value),
    .o_tx(entry_tx), .o_done(entry_done)
  );

  prompt_text u_text (
    .i_msg_id(text_id), .i_idx(text_idx), .i_rdata(rdata),
    .o_byte(text_byte), .o_len(text_len)
  );

endmodule

//--- hdl/tester_ctrl.sv
/* menu FSM, one write or one read per pass through the menu
   the memory request holds until i_mem_ready and is then dropped
   unknown option bytes are ignored */
`timescale 1ns/100ps
`include "sdram_tester_cfg.svh"

module tester_ctrl (
  input  logic                              i_clk,
  input  logic                              i_rstn,
  input  logic                              i_rx_done,
  input  logic [7:0]                        i_rx_data,
  input  logic                              i_mem_ready,
  input  logic [`DATA_W-1:0]                i_mem_rdata,
  output sdram_tester_pkg::mem_req_t        o_mem_req,
  output sdram_tester_pkg::tx_byte_t        o_tx,
  output logic                              o_msg_start,
  output sdram_tester_pkg::msg_id_t         o_msg_id,
  input  logic                              i_msg_done,
  input  sdram_tester_pkg::tx_byte_t        i_pacer_tx,
  output logic                              o_entry_start,
  output logic [$clog2(`DATA_DIGITS+1)-1:0] o_entry_digits,
  input  logic                              i_entry_done,
  input  logic [`DATA_W-1:0]                i_entry_value,
  input  sdram_tester_pkg::tx_byte_t        i_entry_tx,
  output sdram_tester_pkg::data_word_u      o_rdata
);
  import sdram_tester_pkg::*;

  localparam int DIG_W = $clog2(`DATA_DIGITS + 1);

  typedef enum logic [3:0] {
    ST_MENU, ST_WAIT_OPT, ST_WR_PROMPT, ST_WR_DATA, ST_WA_PROMPT, ST_WR_ADDR,
    ST_WR_REQ, ST_WR_OK, ST_RD_PROMPT, ST_RD_ADDR, ST_RD_REQ, ST_RD_PRINT
  } state_t;

  state_t             state;
  state_t             msg_next;       // follows a finished message
  logic               launched;       // start already pulsed in this state
  logic               is_msg_state;
  logic               is_entry_state;
  logic               req_valid;
  logic [3:0]         req_wstrb;
  logic [`ADDR_W-1:0] addr_q;
  logic [`DATA_W-1:0] wdata_q;

  always_comb
  begin
    is_msg_state = 1'b0;
    is_entry_state = 1'b0;
    o_msg_id = MSG_MENU;
    msg_next = ST_WAIT_OPT;
    o_entry_digits = DIG_W'(`ADDR_DIGITS);
    case (state)
      ST_MENU:
        is_msg_state = 1'b1;
      ST_WR_PROMPT:
      begin
        is_msg_state = 1'b1;
        o_msg_id = MSG_WRITE;
        msg_next = ST_WR_DATA;
      end
      ST_WA_PROMPT:
      begin
        is_msg_state = 1'b1;
        o_msg_id = MSG_WADDR;
        msg_next = ST_WR_ADDR;
      end
      ST_WR_OK:
      begin
        is_msg_state = 1'b1;
        o_msg_id = MSG_WOK;
        msg_next = ST_MENU;
      end
      ST_RD_PROMPT:
      begin
        is_msg_state = 1'b1;
        o_msg_id = MSG_READ;
        msg_next = ST_RD_ADDR;
      end
      ST_RD_PRINT:
      begin
        is_msg_state = 1'b1;
        o_msg_id = MSG_RDATA;
        msg_next = ST_MENU;
      end
      ST_WR_DATA:
      begin
        is_entry_state = 1'b1;
        o_entry_digits = DIG_W'(`DATA_DIGITS);
      end
      ST_WR_ADDR, ST_RD_ADDR:
        is_entry_state = 1'b1;
      default:
        is_msg_state = 1'b0;
    endcase
  end

  always_ff @(posedge i_clk)
  begin
    if (!i_rstn)
    begin
      state <= ST_MENU;
      launched <= 1'b0;
      o_msg_start <= 1'b0;
      o_entry_start <= 1'b0;
      req_valid <= 1'b0;
      req_wstrb <= 4'h0;
      o_tx <= '0;
    end
    else
    begin
      o_msg_start <= 1'b0;
      o_entry_start <= 1'b0;
      o_tx <= i_pacer_tx | i_entry_tx;  // never both active
      if (is_msg_state || is_entry_state)
      begin
        if (!launched)
        begin
          launched <= 1'b1;
          o_msg_start <= is_msg_state;
          o_entry_start <= is_entry_state;
        end
        else if (is_msg_state && i_msg_done)
        begin
          launched <= 1'b0;
          state <= msg_next;
        end
        else if (is_entry_state && i_entry_done)
        begin
          launched <= 1'b0;
          if (state == ST_WR_DATA)
            state <= ST_WA_PROMPT;
          else
          begin
            state <= (state == ST_WR_ADDR) ? ST_WR_REQ : ST_RD_REQ;
            req_valid <= 1'b1;  // rises with the address captured below
            req_wstrb <= (state == ST_WR_ADDR) ? 4'hF : 4'h0;
          end
        end
      end
      else if (state == ST_WAIT_OPT)
      begin
        if (i_rx_done && i_rx_data == 8'h31)
          state <= ST_WR_PROMPT;
        else if (i_rx_done && i_rx_data == 8'h32)
          state <= ST_RD_PROMPT;
      end
      else if (i_mem_ready)
      begin
        req_valid <= 1'b0;
        req_wstrb <= 4'h0;
        state <= (state == ST_WR_REQ) ? ST_WR_OK : ST_RD_PRINT;
      end
    end
  end

  always_ff @(posedge i_clk)
  begin
    if (is_entry_state && launched && i_entry_done)
    begin
      if (state == ST_WR_DATA)
        wdata_q <= i_entry_value;
      else
        addr_q <= i_entry_value[`ADDR_W-1:0];
    end
    if (state == ST_RD_REQ && i_mem_ready)
      o_rdata.word <= i_mem_rdata;
  end

  always_comb
  begin
    o_mem_req.valid = req_valid;
    o_mem_req.wstrb = req_wstrb;
    o_mem_req.addr = addr_q;
    o_mem_req.wdata = (req_wstrb == 4'hF) ? wdata_q : '0;  // reads carry no data
  end

endmodule

//--- hdl/tx_pacer.sv
/* sends one message byte per PACE_IDLE_CYCLES idle cycles of tx_busy
   o_tx is combinational, the caller registers it */
`timescale 1ns/100ps
`include "sdram_tester_cfg.svh"

module tx_pacer (
  input  logic                            i_clk,
  input  logic                            i_rstn,
  input  logic                            i_start,
  input  sdram_tester_pkg::msg_id_t       i_msg_id,
  input  logic                            i_tx_busy,
  output sdram_tester_pkg::msg_id_t       o_text_id,
  output logic [$clog2(`MSG_MAX_LEN)-1:0] o_text_idx,
  input  logic [7:0]                      i_text_byte,
  input  logic [$clog2(`MSG_MAX_LEN)-1:0] i_text_len,
  output sdram_tester_pkg::tx_byte_t      o_tx,
  output logic                            o_done
);
  import sdram_tester_pkg::*;

  localparam int IDX_W = $clog2(`MSG_MAX_LEN);
  localparam int CNT_W = $clog2(`PACE_IDLE_CYCLES);

  logic             active;
  msg_id_t          msg_q;
  logic [IDX_W-1:0] idx_q;
  logic [CNT_W-1:0] idle_cnt;
  logic             send;

  // last of the idle cycles in a row
  assign send = active && !i_tx_busy && (idle_cnt == CNT_W'(`PACE_IDLE_CYCLES - 1));
  assign o_text_id = msg_q;
  assign o_text_idx = idx_q;

  always_comb
  begin
    o_tx.en = send;
    o_tx.data = send ? i_text_byte : 8'h00;  // zero when idle, merged by OR
  end

  always_ff @(posedge i_clk)
  begin
    if (!i_rstn)
    begin
      active <= 1'b0;
      msg_q <= MSG_MENU;
      idx_q <= '0;
      idle_cnt <= '0;
      o_done <= 1'b0;
    end
    else
    begin
      o_done <= 1'b0;
      if (i_start)
      begin
        active <= 1'b1;
        msg_q <= i_msg_id;
        idx_q <= '0;
        idle_cnt <= '0;
      end
      else if (active)
      begin
        if (i_tx_busy)
          idle_cnt <= '0;  // back-pressure restarts the count
        else if (send)
        begin
          idle_cnt <= '0;
          if (idx_q == i_text_len - 1'b1)
          begin
            active <= 1'b0;
            o_done <= 1'b1;
          end
          else
            idx_q <= idx_q + 1'b1;
        end
        else
          idle_cnt <= idle_cnt + 1'b1;
      end
    end
  end

endmodule

//--- testbench/sdram_tester_props.sv
/* tx strobe and memory request protocol checks, bound into sdram_tester_top
   assert_fails counts failed assertions for the testbench */
`timescale 1ns/100ps

module sdram_tester_props (
  input logic                       i_clk,
  input logic                       i_rstn,
  input sdram_tester_pkg::tx_byte_t o_tx,
  input sdram_tester_pkg::mem_req_t o_mem_req,
  input logic                       i_mem_ready
);
  int assert_fails = 0;

  // one cycle strobe per byte
  a_tx_single: assert property (@(posedge i_clk) disable iff (!i_rstn)
    o_tx.en |=> !o_tx.en)
  else
  begin
    assert_fails++;
    $error("o_tx.en high in two consecutive cycles");
  end

  // request held as a whole until ready
  a_req_hold: assert property (@(posedge i_clk) disable iff (!i_rstn)
    o_mem_req.valid && !i_mem_ready |=> $stable(o_mem_req))
  else
  begin
    assert_fails++;
    $error("o_mem_req changed before i_mem_ready");
  end

  a_wstrb_valid: assert property (@(posedge i_clk) disable iff (!i_rstn)
    (o_mem_req.wstrb != 4'h0) |-> o_mem_req.valid)
  else
  begin
    assert_fails++;
    $error("o_mem_req.wstrb set without valid");
  end

endmodule

bind sdram_tester_top sdram_tester_props u_props (
  .i_clk(i_clk), .i_rstn(i_rstn), .o_tx(o_tx), .o_mem_req(o_mem_req),
  .i_mem_ready(i_mem_ready)
);

//--- testbench/tb_sdram_tester.sv
/* table driven test of the uart sdram tester with uart and memory models
   expects the default widths of sdram_tester_cfg.svh */
`timescale 1ns/100ps
`include "sdram_tester_cfg.svh"

module tb_sdram_tester;
  import sdram_tester_pkg::*;

  localparam int NUM_ROWS = 7;
  localparam int CYCLE_LIMIT = NUM_ROWS * 3000 + 2000;

  // is_read, data, lower case mask (msb = first digit), address, junk char
  typedef struct packed {
    logic        is_read;
    logic [31:0] data;
    logic [7:0]  lower;
    logic [23:0] addr;
    logic [7:0]  junk;
  } row_t;

  logic               i_clk;
  logic               i_rstn;
  logic               i_rx_done;
  logic [7:0]         i_rx_data;
  logic               i_tx_busy;
  tx_byte_t           o_tx;
  logic               i_mem_ready;
  logic [`DATA_W-1:0] i_mem_rdata;
  mem_req_t           o_mem_req;

  row_t        rows [NUM_ROWS];
  logic [7:0]  transcript[$];
  logic [7:0]  exp_q[$];
  mem_req_t    req_log[$];
  logic [31:0] sdram [logic [23:0]];
  logic [31:0] ref_mem [logic [23:0]];
  logic [31:0] rng_state = 32'he011;
  int          busy_cnt = 0;
  int          mem_wait = 0;
  int          checked = 0;
  int          n_req = 0;
  int          n_checks = 0;
  int          n_errors = 0;
  int          cycles = 0;

  sdram_tester_top u_dut (
    .i_clk(i_clk), .i_rstn(i_rstn), .i_rx_done(i_rx_done), .i_rx_data(i_rx_data),
    .i_tx_busy(i_tx_busy), .o_tx(o_tx), .i_mem_ready(i_mem_ready),
    .i_mem_rdata(i_mem_rdata), .o_mem_req(o_mem_req)
  );

  always #20 i_clk = ~i_clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [7:0] hex_ascii(input logic [3:0] nib, input logic lower);
    if (nib < 4'd10)
      return 8'h30 + nib;
    else if (lower)
      return 8'h61 + nib - 8'd10;
    else
      return 8'h41 + nib - 8'd10;
  endfunction

  // uart transmitter, busy for 10 cycles per byte
  always @(negedge i_clk)
  begin
    if (o_tx.en)
    begin
      transcript.push_back(o_tx.data);
      busy_cnt = 10;
    end
    else if (busy_cnt != 0)
      busy_cnt--;
    i_tx_busy = (busy_cnt != 0);
  end

  // sdram, ready 1 to 6 cycles after valid
  always @(negedge i_clk)
  begin
    if (i_mem_ready)
      i_mem_ready = 1'b0;  // valid drops on this edge
    else if (mem_wait != 0)
    begin
      mem_wait--;
      if (mem_wait == 0)
      begin
        i_mem_ready = 1'b1;
        req_log.push_back(o_mem_req);
        if (o_mem_req.wstrb == 4'hF)
          sdram[o_mem_req.addr] = o_mem_req.wdata;
        else
          i_mem_rdata = sdram.exists(o_mem_req.addr) ? sdram[o_mem_req.addr] : 32'h0;
      end
    end
    else if (o_mem_req.valid)
    begin
      rng_state = xorshift(rng_state);
      mem_wait = 1 + (rng_state % 6);
    end
  end

  always @(posedge i_clk)
  begin
    cycles++;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("timeout after %0d cycles, the tester stopped responding", cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic expect_text(input string s);
    for (int i = 0; i < s.len(); i++)
      exp_q.push_back(s[i]);
  endtask

  task automatic expect_menu();
    expect_text("SDRAM TESTER\015\012Options: 1-Write, 2-Read\015\012");
  endtask

  // waits for all expected bytes, then compares the new ones
  task automatic wait_and_check();
    while (transcript.size() < exp_q.size())
      @(negedge i_clk);
    for (int i = checked; i < exp_q.size(); i++)
      check_value("o_tx.data", transcript[i], exp_q[i]);
    checked = exp_q.size();
  endtask

  task automatic send_byte(input logic [7:0] b);
    repeat (20) @(negedge i_clk);
    i_rx_data = b;
    i_rx_done = 1'b1;
    @(negedge i_clk);
    i_rx_done = 1'b0;
  endtask

  // junk goes in front of the third digit, never echoed
  task automatic send_digits(input logic [31:0] value, input int ndig,
                             input logic [7:0] lower, input logic [7:0] junk);
    logic [7:0] c;
    for (int i = 0; i < ndig; i++)
    begin
      if (i == 2 && junk != 8'h00)
        send_byte(junk);
      c = hex_ascii(value[4*(ndig-1-i) +: 4], lower[7-i]);
      send_byte(c);
      exp_q.push_back(c);
    end
    wait_and_check();
  endtask

  task automatic check_request(input row_t row);
    n_req++;
    check_value("request count", req_log.size(), n_req);
    if (req_log.size() == n_req)
    begin
      check_value("o_mem_req.valid", req_log[n_req-1].valid, 1'b1);
      check_value("o_mem_req.wstrb", req_log[n_req-1].wstrb, row.is_read ? 4'h0 : 4'hF);
      check_value("o_mem_req.addr", req_log[n_req-1].addr, row.addr);
      if (!row.is_read)
        check_value("o_mem_req.wdata", req_log[n_req-1].wdata, row.data);
    end
  endtask

  task automatic run_write(input row_t row);
    send_byte("1");
    expect_text("WRITE\015\012Enter 32-bit data:\015\012");
    wait_and_check();
    send_digits(row.data, 8, row.lower, row.junk);
    expect_text("\015\012Enter 24-bit address:\015\012");
    wait_and_check();
    send_digits({8'h00, row.addr}, 6, 8'h00, 8'h00);
    expect_text("\015\012Data write ok!\015\012");
    expect_menu();
    wait_and_check();
    check_request(row);
    ref_mem[row.addr] = row.data;
  endtask

  task automatic run_read(input row_t row);
    logic [31:0] word;
    word = ref_mem.exists(row.addr) ? ref_mem[row.addr] : 32'h0;
    send_byte("2");
    expect_text("READ\015\012Enter 24-bit address:\015\012");
    wait_and_check();
    send_digits({8'h00, row.addr}, 6, row.lower, row.junk);
    expect_text("\015\012Read data: ");
    for (int i = 7; i >= 0; i--)
      exp_q.push_back(hex_ascii(word[4*i +: 4], 1'b0));
    expect_text("\015\012");
    expect_menu();
    wait_and_check();
    check_request(row);
  endtask

  initial
  begin
    rows[0] = {1'b0, 32'hDEADBEEF, 8'hA5, 24'h001234, "x"};
    rows[1] = {1'b1, 32'h0, 8'h00, 24'h001234, 8'h00};
    rows[2] = {1'b0, 32'h0123ABCD, 8'h0F, 24'hABCDEF, "?"};
    rows[3] = {1'b1, 32'h0, 8'h00, 24'h000777, "Z"};  // never written
    rows[4] = {1'b1, 32'h0, 8'hFC, 24'hABCDEF, 8'h00};
    rows[5] = {1'b0, 32'hCAFEF00D, 8'hFF, 24'h001234, " "};
    rows[6] = {1'b1, 32'h0, 8'h00, 24'h001234, "G"};
  end

  initial
  begin
    i_clk = 1'b0;
    i_rstn = 1'b0;
    i_rx_done = 1'b0;
    i_rx_data = 8'h00;
    i_tx_busy = 1'b0;
    i_mem_ready = 1'b0;
    i_mem_rdata = '0;
    repeat (5) @(negedge i_clk);
    i_rstn = 1'b1;

    expect_menu();
    wait_and_check();
    check_value("request count", req_log.size(), 0);

    for (int r = 0; r < NUM_ROWS; r++)
    begin
      if (rows[r].junk != 8'h00)
      begin
        send_byte(rows[r].junk);  // unknown option, must stay silent
        repeat (40) @(negedge i_clk);
        check_value("transcript length", transcript.size(), exp_q.size());
        check_value("request count", req_log.size(), n_req);
      end
      if (rows[r].is_read)
        run_read(rows[r]);
      else
        run_write(rows[r]);
    end

    repeat (200) @(negedge i_clk);
    check_value("transcript length", transcript.size(), exp_q.size());
    check_value("request count", req_log.size(), n_req);

    $display("checks: %0d, errors: %0d, assertion failures: %0d",
             n_checks, n_errors, u_dut.u_props.assert_fails);
    if (n_errors == 0 && u_dut.u_props.assert_fails == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule
